//--- src/store_geom_pkg.sv
`default_nettype none

package store_geom_pkg;

  //////////////////////////////////////////////////
  // systolic array and fifo geometry
  //////////////////////////////////////////////////
  localparam int sa_rows     = 4;
  localparam int sa_cols     = 3;
  localparam int fifo_count  = sa_rows * sa_cols;
  // output channels held by one sa row fifo group
  localparam int rows_per_sa = 16;

  //////////////////////////////////////////////////
  // word and field widths
  //////////////////////////////////////////////////
  localparam int fifo_word_bits = 512;
  localparam int conv_word_bits = fifo_word_bits / 2;
  localparam int ddr_word_bits  = 512;
  localparam int addr_bits      = 32;
  localparam int tile_idx_bits  = 16;
  localparam int log2_bits      = 4;
  localparam int burst_len_bits = 16;

  // ddr layout of the output feature map
  localparam int pixels_per_row_log2 = 5;
  localparam int chans_per_word_log2 = 1;
  localparam int max_burst_words     = 32;
  localparam int max_burst_chans     = max_burst_words << chans_per_word_log2;

  // word address of one channel pair; all indices count from one
  function automatic logic [addr_bits-1:0] ddr_word_addr(
    input logic [addr_bits-1:0]     base,
    input logic [tile_idx_bits-1:0] x_start,
    input logic [tile_idx_bits-1:0] y_start,
    input logic [tile_idx_bits-1:0] f_start,
    input logic [tile_idx_bits-1:0] row,
    input logic [tile_idx_bits-1:0] chan,
    input logic [log2_bits-1:0]     f_log2,
    input logic [log2_bits-1:0]     x_log2
  );
    logic [addr_bits-1:0] row_abs;
    logic [addr_bits-1:0] chan_abs;
    logic [addr_bits-1:0] x_words;
    logic [5:0]           row_shift;
    row_abs   = addr_bits'(y_start) + addr_bits'(row) - 2;
    chan_abs  = addr_bits'(f_start) + addr_bits'(chan) - 2;
    x_words   = (addr_bits'(x_start) - 1) << (f_log2 - log2_bits'(chans_per_word_log2));
    x_words   = x_words >> pixels_per_row_log2;
    // one output row spans all channels of all pixels in the row
    row_shift = 6'(f_log2) + 6'(x_log2) - 6'(chans_per_word_log2 + pixels_per_row_log2);
    return base + (row_abs << row_shift) + x_words + (chan_abs >> chans_per_word_log2);
  endfunction

endpackage

`default_nettype wire

//--- src/store_types_pkg.sv
`default_nettype none

package store_types_pkg;
  import store_geom_pkg::*;

  typedef logic [addr_bits-1:0]      ddr_addr_t;
  // tile starts, sizes and loop counters
  typedef logic [tile_idx_bits-1:0]  tile_idx_t;
  typedef logic [log2_bits-1:0]      log2_t;
  typedef logic [burst_len_bits-1:0] burst_len_t;

  typedef logic [ddr_word_bits-1:0]  ddr_word_t;
  typedef logic [conv_word_bits-1:0] conv_word_t;
  // one read strobe per row fifo
  typedef logic [fifo_count-1:0]     fifo_sel_t;

  typedef enum logic {
    mode_pack_halves = 1'b0,
    mode_full_word   = 1'b1
  } store_mode_e;

endpackage

`default_nettype wire

//--- src/store_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// store command handoff from the command generator to the walker
interface store_cmd_if;
  import store_types_pkg::*;

  logic       cmd_valid;
  burst_len_t cmd_len;
  // high from the command until the last word of its burst
  logic       burst_busy;
  logic       tile_done;

  modport cmd (
    output cmd_valid, cmd_len,
    input  burst_busy, tile_done
  );

  modport walk (
    input  cmd_valid, cmd_len,
    output burst_busy, tile_done
  );

endinterface

`default_nettype wire

//--- src/store_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// fifo read pacing between the walker and the word packer
interface store_word_if;

  logic rd_strobe;
  logic rd_even;
  logic tile_last;
  // low while a word still waits for write ready
  logic can_read;
  logic word_valid;

  modport walk (
    output rd_strobe, rd_even, tile_last,
    input  can_read, word_valid
  );

  modport pack (
    input  rd_strobe, rd_even, tile_last,
    output can_read, word_valid
  );

endinterface

`default_nettype wire

//--- src/store_cmd_gen.sv
`timescale 1ns/1ps
`default_nettype none

module store_cmd_gen (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             start,
  input  wire                             ddr_cmd_ready,
  input  wire store_types_pkg::ddr_addr_t base,
  input  wire store_types_pkg::log2_t     of_log2,
  input  wire store_types_pkg::log2_t     ox_log2,
  input  wire store_types_pkg::tile_idx_t ox_start,
  input  wire store_types_pkg::tile_idx_t oy_start,
  input  wire store_types_pkg::tile_idx_t of_start,
  input  wire store_types_pkg::tile_idx_t poy,
  input  wire store_types_pkg::tile_idx_t pof,
  output store_types_pkg::ddr_addr_t      store_ddr_base_adr,
  output store_types_pkg::burst_len_t     store_ddr_length,
  output logic                            valid_store_ddr_cmd,
  store_cmd_if.cmd                        cmd
);
  import store_geom_pkg::*;
  import store_types_pkg::*;

  logic      tile_active;
  logic      cmd_lock;
  logic      cmd_go;
  tile_idx_t store_of;
  tile_idx_t store_oy;
  tile_idx_t chans_left;
  tile_idx_t cmd_chans;
  logic      of_end;
  logic      oy_end;

  //////////////////////////////////////////////////
  // command issue
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      tile_active <= 1'b0;
    end else if (start) begin
      tile_active <= 1'b1;
    end else if (cmd.tile_done) begin
      tile_active <= 1'b0;
    end
  end

  // blocks a second command before the walker raises busy
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_lock <= 1'b0;
    end else if (valid_store_ddr_cmd) begin
      cmd_lock <= 1'b0;
    end else if (cmd_go) begin
      cmd_lock <= 1'b1;
    end
  end

  assign cmd_go = tile_active && !cmd.burst_busy && ddr_cmd_ready && !cmd_lock;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_store_ddr_cmd <= 1'b0;
    end else begin
      valid_store_ddr_cmd <= cmd_go;
    end
  end

  assign chans_left = pof - store_of + 1;

  // a short last burst takes the channels that remain in the row
  always_ff @(posedge clk) begin
    if (cmd_go) begin
      if (chans_left < tile_idx_t'(max_burst_chans)) begin
        store_ddr_length <= burst_len_t'(chans_left >> chans_per_word_log2);
      end else begin
        store_ddr_length <= burst_len_t'(max_burst_words);
      end
      store_ddr_base_adr <= ddr_word_addr(base, ox_start, oy_start, of_start,
                                          store_oy, store_of, of_log2, ox_log2);
    end
  end

  //////////////////////////////////////////////////
  // channel and row position of the next command
  //////////////////////////////////////////////////
  assign cmd_chans = tile_idx_t'(store_ddr_length) << chans_per_word_log2;
  assign of_end    = valid_store_ddr_cmd && (store_of + cmd_chans > pof);
  assign oy_end    = of_end && (store_oy == poy);

  always_ff @(posedge clk) begin
    if (reset) begin
      store_of <= 1;
      store_oy <= 1;
    end else if (valid_store_ddr_cmd) begin
      if (of_end) begin
        store_of <= 1;
        store_oy <= oy_end ? tile_idx_t'(1) : store_oy + 1;
      end else begin
        store_of <= store_of + cmd_chans;
      end
    end
  end

  assign cmd.cmd_valid = valid_store_ddr_cmd;
  assign cmd.cmd_len   = store_ddr_length;

  // the walker must have finished the previous burst
  assert property (@(posedge clk) disable iff (reset)
    cmd.cmd_valid |-> !cmd.burst_busy);

endmodule

`default_nettype wire

//--- src/tile_read_walker.sv
`timescale 1ns/1ps
`default_nettype none

module tile_read_walker (
  input  wire                               clk,
  input  wire                               reset,
  input  wire store_types_pkg::store_mode_e mode,
  input  wire store_types_pkg::ddr_addr_t   base,
  input  wire store_types_pkg::log2_t       of_log2,
  input  wire store_types_pkg::log2_t       ox_log2,
  input  wire store_types_pkg::tile_idx_t   ox_start,
  input  wire store_types_pkg::tile_idx_t   oy_start,
  input  wire store_types_pkg::tile_idx_t   of_start,
  input  wire store_types_pkg::tile_idx_t   poy,
  input  wire store_types_pkg::tile_idx_t   pof,
  output store_types_pkg::fifo_sel_t        fifo_rds,
  output store_types_pkg::ddr_addr_t        conv_out_ddr_adr,
  store_cmd_if.walk                         cmd,
  store_word_if.walk                        wrd
);
  import store_geom_pkg::*;
  import store_types_pkg::*;

  logic       burst_busy;
  burst_len_t burst_len;
  burst_len_t word_cnt;
  logic       burst_end;
  logic       rd_go;
  // loop counters, all one based
  tile_idx_t  chan_cnt;
  tile_idx_t  group_base;
  tile_idx_t  row_cnt;
  tile_idx_t  chan_step;
  tile_idx_t  group_chans;
  log2_t      group_log2;
  tile_idx_t  fifo_idx;
  logic       chan_end;
  logic       group_end;
  logic       row_end;

  //////////////////////////////////////////////////
  // burst tracking
  //////////////////////////////////////////////////
  assign burst_end = wrd.word_valid && (word_cnt == burst_len);

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_busy <= 1'b0;
    end else if (cmd.cmd_valid) begin
      burst_busy <= 1'b1;
    end else if (burst_end) begin
      burst_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      word_cnt <= 1;
    end else if (burst_end) begin
      word_cnt <= 1;
    end else if (wrd.word_valid) begin
      word_cnt <= word_cnt + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.cmd_valid) begin
      burst_len <= cmd.cmd_len;
    end
  end

  //////////////////////////////////////////////////
  // channel, group and row loops
  //////////////////////////////////////////////////
  // full words hold two channels, and a group holds twice as many
  assign chan_step   = tile_idx_t'(1) << mode;
  assign group_chans = tile_idx_t'(rows_per_sa) << mode;
  assign group_log2  = log2_t'($clog2(rows_per_sa)) + log2_t'(mode);

  assign rd_go     = burst_busy && wrd.can_read;
  assign chan_end  = rd_go && ((group_base - 1 + chan_cnt + chan_step > pof) ||
                               (chan_cnt + chan_step > group_chans));
  assign group_end = chan_end && (group_base - 1 + group_chans >= pof);
  assign row_end   = group_end && (row_cnt == poy);

  always_ff @(posedge clk) begin
    if (reset) begin
      chan_cnt   <= 1;
      group_base <= 1;
      row_cnt    <= 1;
    end else if (rd_go) begin
      if (!chan_end) begin
        chan_cnt <= chan_cnt + chan_step;
      end else begin
        chan_cnt <= 1;
        if (!group_end) begin
          group_base <= group_base + group_chans;
        end else begin
          group_base <= 1;
          row_cnt    <= row_end ? tile_idx_t'(1) : row_cnt + 1;
        end
      end
    end
  end

  // fifos are numbered row major over the sa grid
  assign fifo_idx = (row_cnt - 1) * tile_idx_t'(sa_rows) + ((group_base - 1) >> group_log2);
  assign fifo_rds = rd_go ? (fifo_sel_t'(1) << fifo_idx) : '0;

  always_ff @(posedge clk) begin
    if (rd_go) begin
      conv_out_ddr_adr <= ddr_word_addr(base, ox_start, oy_start, of_start, row_cnt,
                                        group_base - 1 + chan_cnt, of_log2, ox_log2);
    end
  end

  assign cmd.burst_busy = burst_busy;
  assign cmd.tile_done  = row_end;
  assign wrd.rd_strobe  = rd_go;
  assign wrd.rd_even    = !chan_cnt[0];
  assign wrd.tile_last  = row_end;

  // every read lands on one existing fifo
  assert property (@(posedge clk) disable iff (reset)
    $onehot0(fifo_rds) && (wrd.rd_strobe == (fifo_rds != '0)));

endmodule

`default_nettype wire

//--- src/ddr_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_word_packer (
  input  wire                               clk,
  input  wire                               reset,
  input  wire store_types_pkg::store_mode_e mode,
  input  wire                               ddr_wt_data_ready,
  input  wire store_types_pkg::ddr_word_t   fifo_data,
  output store_types_pkg::ddr_word_t        conv_out_ddr_data,
  output logic                              valid_conv_out_ddr_data,
  output logic                              conv_store_fin,
  store_word_if.pack                        wrd
);
  import store_geom_pkg::*;
  import store_types_pkg::*;

  logic       emit;
  logic       word_lock;
  logic       half_pend;
  logic       last_pend;
  logic       ready_owed;
  conv_word_t cur_half;
  conv_word_t prev_half;

  // an odd channel read only supplies the low half
  assign emit     = wrd.rd_strobe && ((mode == mode_full_word) || wrd.rd_even);
  assign cur_half = fifo_data[conv_word_bits-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      word_lock <= 1'b0;
    end else if (emit) begin
      word_lock <= 1'b1;
    end else if (ddr_wt_data_ready) begin
      word_lock <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_conv_out_ddr_data <= 1'b0;
      half_pend               <= 1'b0;
      last_pend               <= 1'b0;
      conv_store_fin          <= 1'b0;
    end else begin
      valid_conv_out_ddr_data <= emit;
      half_pend               <= wrd.rd_strobe && !emit;
      last_pend               <= emit && wrd.tile_last;
      conv_store_fin          <= valid_conv_out_ddr_data && last_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (half_pend) begin
      prev_half <= cur_half;
    end
  end

  always_comb begin
    if (!valid_conv_out_ddr_data) begin
      conv_out_ddr_data = '0;
    end else if (mode == mode_full_word) begin
      conv_out_ddr_data = fifo_data;
    end else begin
      conv_out_ddr_data = {cur_half, prev_half};
    end
  end

  assign wrd.can_read   = !word_lock;
  assign wrd.word_valid = valid_conv_out_ddr_data;

  //////////////////////////////////////////////////
  // write ready pacing check
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      ready_owed <= 1'b0;
    end else if (ddr_wt_data_ready) begin
      ready_owed <= 1'b0;
    end else if (valid_conv_out_ddr_data) begin
      ready_owed <= 1'b1;
    end
  end

  // no new word before write ready has been seen
  assert property (@(posedge clk) disable iff (reset)
    ready_owed |-> !valid_conv_out_ddr_data);

endmodule

`default_nettype wire

//--- src/conv_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_store_top (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               conv_store_start_sig,
  input  wire                               ddr_cmd_ready,
  input  wire                               ddr_wt_data_ready,
  input  wire store_types_pkg::ddr_addr_t   output_ddr_layer_base_adr_init,
  input  wire store_types_pkg::store_mode_e mode_init,
  input  wire store_types_pkg::log2_t       of_in_2pow,
  input  wire store_types_pkg::log2_t       ox_in_2pow,
  input  wire store_types_pkg::tile_idx_t   cur_ox_start,
  input  wire store_types_pkg::tile_idx_t   cur_oy_start,
  input  wire store_types_pkg::tile_idx_t   cur_of_start,
  input  wire store_types_pkg::tile_idx_t   cur_pox,
  input  wire store_types_pkg::tile_idx_t   cur_poy,
  input  wire store_types_pkg::tile_idx_t   cur_pof,
  input  wire store_types_pkg::ddr_word_t   fifo_data,
  output store_types_pkg::ddr_addr_t        store_ddr_base_adr,
  output store_types_pkg::burst_len_t       store_ddr_length,
  output logic                              valid_store_ddr_cmd,
  output store_types_pkg::fifo_sel_t        fifo_rds,
  output store_types_pkg::ddr_addr_t        conv_out_ddr_adr,
  output store_types_pkg::ddr_word_t        conv_out_ddr_data,
  output logic                              valid_conv_out_ddr_data,
  output logic                              conv_store_fin
);
  import store_types_pkg::*;

  logic        start_q;
  store_mode_e mode_q;
  ddr_addr_t   base_q;

  store_cmd_if  cmd_bus ();
  store_word_if word_bus ();

  // tile inputs settle one cycle after the start strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= conv_store_start_sig;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mode_q <= mode_pack_halves;
    end else if (start_q) begin
      mode_q <= mode_init;
    end
  end

  always_ff @(posedge clk) begin
    if (start_q) begin
      base_q <= output_ddr_layer_base_adr_init;
    end
  end

  //////////////////////////////////////////////////
  // command, read and pack stages
  //////////////////////////////////////////////////
  store_cmd_gen i_store_cmd_gen (
    .clk                 (clk),
    .reset               (reset),
    .start               (start_q),
    .ddr_cmd_ready       (ddr_cmd_ready),
    .base                (base_q),
    .of_log2             (of_in_2pow),
    .ox_log2             (ox_in_2pow),
    .ox_start            (cur_ox_start),
    .oy_start            (cur_oy_start),
    .of_start            (cur_of_start),
    .poy                 (cur_poy),
    .pof                 (cur_pof),
    .store_ddr_base_adr  (store_ddr_base_adr),
    .store_ddr_length    (store_ddr_length),
    .valid_store_ddr_cmd (valid_store_ddr_cmd),
    .cmd                 (cmd_bus.cmd)
  );

  tile_read_walker i_tile_read_walker (
    .clk              (clk),
    .reset            (reset),
    .mode             (mode_q),
    .base             (base_q),
    .of_log2          (of_in_2pow),
    .ox_log2          (ox_in_2pow),
    .ox_start         (cur_ox_start),
    .oy_start         (cur_oy_start),
    .of_start         (cur_of_start),
    .poy              (cur_poy),
    .pof              (cur_pof),
    .fifo_rds         (fifo_rds),
    .conv_out_ddr_adr (conv_out_ddr_adr),
    .cmd              (cmd_bus.walk),
    .wrd              (word_bus.walk)
  );

  ddr_word_packer i_ddr_word_packer (
    .clk                     (clk),
    .reset                   (reset),
    .mode                    (mode_q),
    .ddr_wt_data_ready       (ddr_wt_data_ready),
    .fifo_data               (fifo_data),
    .conv_out_ddr_data       (conv_out_ddr_data),
    .valid_conv_out_ddr_data (valid_conv_out_ddr_data),
    .conv_store_fin          (conv_store_fin),
    .wrd                     (word_bus.pack)
  );

  // tile covers whole channel pairs and sits inside one output row
  assert property (@(posedge clk) disable iff (reset)
    start_q |-> (cur_pof[0] == 1'b0) &&
                (32'(cur_ox_start) - 1 + 32'(cur_pox) <= (32'd1 << ox_in_2pow)));

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);
  localparam int half_period  = 4;
  localparam int reset_cycles = 5;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset drops on a falling edge like the other inputs
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/conv_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_store_tb;
  import store_geom_pkg::*;
  import store_types_pkg::*;

  localparam int tile_count    = 12;
  localparam int tile_timeout  = 20000;
  localparam int reset_timeout = 50;
  localparam int idle_cycles   = 12;

  logic        clk;
  logic        reset;
  logic        conv_store_start_sig;
  logic        ddr_cmd_ready;
  logic        ddr_wt_data_ready;
  ddr_addr_t   output_ddr_layer_base_adr_init;
  store_mode_e mode_init;
  log2_t       of_in_2pow;
  log2_t       ox_in_2pow;
  tile_idx_t   cur_ox_start;
  tile_idx_t   cur_oy_start;
  tile_idx_t   cur_of_start;
  tile_idx_t   cur_pox;
  tile_idx_t   cur_poy;
  tile_idx_t   cur_pof;
  ddr_word_t   fifo_data;
  ddr_addr_t   store_ddr_base_adr;
  burst_len_t  store_ddr_length;
  logic        valid_store_ddr_cmd;
  fifo_sel_t   fifo_rds;
  ddr_addr_t   conv_out_ddr_adr;
  ddr_word_t   conv_out_ddr_data;
  logic        valid_conv_out_ddr_data;
  logic        conv_store_fin;

  // current tile
  store_mode_e t_mode;
  ddr_addr_t   t_base;
  log2_t       t_of_log2;
  log2_t       t_ox_log2;
  tile_idx_t   t_ox_start;
  tile_idx_t   t_oy_start;
  tile_idx_t   t_of_start;
  tile_idx_t   t_pox;
  tile_idx_t   t_poy;
  tile_idx_t   t_pof;
  int          tile_no;

  // applied at the next falling edge
  logic load_cfg;
  logic start_req;
  logic scramble_req;

  // expected traffic of the tile
  ddr_addr_t  cmd_addr_q[$];
  burst_len_t cmd_len_q[$];
  int         read_idx_q[$];
  ddr_addr_t  word_addr_q[$];
  ddr_word_t  word_data_q[$];

  int          read_count[fifo_count];
  logic        rd_pend;
  int          rd_pend_idx;
  int          cmd_span;
  int          wt_span;
  logic        fin_next;
  int          fin_seen;
  int          burst_words;
  int          errors;
  logic [31:0] lfsr_state;

  tb_clock_gen i_tb_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  conv_store_top i_conv_store_top (.*);

  //////////////////////////////////////////////////
  // random numbers and reference rules
  //////////////////////////////////////////////////
  function automatic logic lfsr_step();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // 0 up to n-1
  function automatic int draw_range(input int n);
    return int'(draw_bits(16) % 32'(n));
  endfunction

  // word address of a channel pair, indices one based
  function automatic ddr_addr_t pixel_pair_addr(input int row, input int chan);
    ddr_addr_t row_abs;
    ddr_addr_t chan_abs;
    ddr_addr_t row_pitch;
    ddr_addr_t x_off;
    row_abs   = ddr_addr_t'(int'(t_oy_start) + row - 2);
    chan_abs  = ddr_addr_t'(int'(t_of_start) + chan - 2);
    row_pitch = ddr_addr_t'(1) << (int'(t_of_log2) + int'(t_ox_log2) - 1 - 5);
    x_off     = ddr_addr_t'(int'(t_ox_start) - 1) * ((ddr_addr_t'(1) << t_of_log2) / 2) / 32;
    return t_base + row_abs * row_pitch + x_off + chan_abs / 2;
  endfunction

  // contents of one fifo entry
  function automatic ddr_word_t fifo_word(input int idx, input int cnt);
    ddr_word_t w;
    int        lane;
    for (lane = 0; lane < 16; lane++) begin
      w[lane*32 +: 32] = {8'(tile_no), 4'(idx), 4'(lane), 16'(cnt)};
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // error reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic stop_run(input string why);
    errors++;
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("[FAIL] %0t ns: %s", $time, what));
  endtask

  task automatic check_cmd(input ddr_addr_t got_addr, input burst_len_t got_len,
                           input ddr_addr_t exp_addr, input burst_len_t exp_len);
    if (got_addr !== exp_addr || got_len !== exp_len) begin
      report_mismatch($sformatf("store command addr %h len %0d, expected addr %h len %0d",
                                got_addr, got_len, exp_addr, exp_len));
    end
  endtask

  task automatic check_word(input ddr_addr_t got_addr, input ddr_word_t got_data,
                            input ddr_addr_t exp_addr, input ddr_word_t exp_data);
    if (got_addr !== exp_addr) begin
      report_mismatch($sformatf("ddr word addr %h, expected %h", got_addr, exp_addr));
    end
    if (got_data !== exp_data) begin
      report_mismatch($sformatf("ddr word at %h is %h, expected %h",
                                got_addr, got_data, exp_data));
    end
  endtask

  task automatic check_read(input fifo_sel_t got, input fifo_sel_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("fifo_rds %b, expected %b", got, exp));
    end
  endtask

  task automatic check_fin(input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("conv_store_fin %b, expected %b", got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // per cycle driving and checking
  //////////////////////////////////////////////////
  task automatic drive_lines();
    if (rd_pend) begin
      fifo_data = fifo_word(rd_pend_idx, read_count[rd_pend_idx]);
      read_count[rd_pend_idx]++;
      rd_pend = 1'b0;
    end
    // ready levels hold for random spans
    if (cmd_span == 0) begin
      ddr_cmd_ready = (draw_bits(2) != 0);
      cmd_span      = 1 + draw_range(6);
    end
    cmd_span--;
    if (wt_span == 0) begin
      ddr_wt_data_ready = draw_bits(1) != 0;
      wt_span           = 1 + draw_range(8);
    end
    wt_span--;
    conv_store_start_sig = start_req;
    start_req            = 1'b0;
    if (load_cfg) begin
      mode_init                      = t_mode;
      output_ddr_layer_base_adr_init = t_base;
      of_in_2pow                     = t_of_log2;
      ox_in_2pow                     = t_ox_log2;
      cur_ox_start                   = t_ox_start;
      cur_oy_start                   = t_oy_start;
      cur_of_start                   = t_of_start;
      cur_pox                        = t_pox;
      cur_poy                        = t_poy;
      cur_pof                        = t_pof;
      load_cfg                       = 1'b0;
    end
    // mode and base must already be captured
    if (scramble_req) begin
      mode_init                      = store_mode_e'(draw_bits(1));
      output_ddr_layer_base_adr_init = draw_bits(32);
      scramble_req                   = 1'b0;
    end
  endtask

  task automatic sample_and_check();
    int idx;
    check_fin(conv_store_fin, fin_next);
    if (conv_store_fin) begin
      fin_seen++;
    end
    fin_next = 1'b0;
    if (valid_store_ddr_cmd) begin
      if (cmd_addr_q.size() == 0) begin
        report_mismatch($sformatf("unexpected store command at %h", store_ddr_base_adr));
      end else begin
        check_cmd(store_ddr_base_adr, store_ddr_length,
                  cmd_addr_q.pop_front(), cmd_len_q.pop_front());
        burst_words += int'(store_ddr_length);
      end
    end
    if (fifo_rds != '0) begin
      if (read_idx_q.size() == 0) begin
        report_mismatch($sformatf("unexpected fifo read %b", fifo_rds));
      end else begin
        idx = read_idx_q.pop_front();
        check_read(fifo_rds, fifo_sel_t'(1) << idx);
        rd_pend     = 1'b1;
        rd_pend_idx = idx;
      end
    end
    if (valid_conv_out_ddr_data) begin
      if (word_addr_q.size() == 0) begin
        report_mismatch($sformatf("unexpected ddr word at %h", conv_out_ddr_adr));
      end else begin
        check_word(conv_out_ddr_adr, conv_out_ddr_data,
                   word_addr_q.pop_front(), word_data_q.pop_front());
        // finish follows the last word by one cycle
        fin_next = (word_addr_q.size() == 0);
      end
    end else if (conv_out_ddr_data != '0) begin
      report_mismatch("ddr data not zero while its valid is low");
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    drive_lines();
    #1;
    sample_and_check();
  endtask

  //////////////////////////////////////////////////
  // tile setup and reference model
  //////////////////////////////////////////////////
  task automatic draw_tile();
    int gsize;
    int max_pof;
    tile_no++;
    t_mode    = store_mode_e'(draw_bits(1));
    t_of_log2 = log2_t'(6 + draw_range(2));
    t_ox_log2 = log2_t'(5 + draw_range(2));
    gsize     = rows_per_sa << int'(t_mode);
    max_pof   = sa_rows * gsize;
    if ((1 << int'(t_of_log2)) < max_pof) begin
      max_pof = 1 << int'(t_of_log2);
    end
    t_pof      = tile_idx_t'(2 * (1 + draw_range(max_pof / 2)));
    t_poy      = tile_idx_t'(1 + draw_range(sa_cols));
    t_of_start = tile_idx_t'(1 + 2 * draw_range(((1 << int'(t_of_log2)) - int'(t_pof)) / 2 + 1));
    t_pox      = tile_idx_t'(1 + draw_range(8));
    t_ox_start = tile_idx_t'(1 + draw_range((1 << int'(t_ox_log2)) - int'(t_pox) + 1));
    t_oy_start = tile_idx_t'(1 + draw_range(16));
    t_base     = draw_bits(32);
  endtask

  task automatic build_model();
    int         row;
    int         ch_pos;
    int         left;
    int         len;
    int         grp;
    int         c;
    int         ch;
    int         idx;
    int         step;
    int         gsize;
    int         cnt[fifo_count];
    ddr_word_t  data;
    conv_word_t low_prev;
    low_prev = '0;
    for (idx = 0; idx < fifo_count; idx++) begin
      cnt[idx]        = 0;
      read_count[idx] = 0;
    end
    // one command per row segment of up to 64 channels
    for (row = 1; row <= int'(t_poy); row++) begin
      ch_pos = 1;
      while (ch_pos <= int'(t_pof)) begin
        left = int'(t_pof) - ch_pos + 1;
        len  = (left < 2 * max_burst_words) ? left / 2 : max_burst_words;
        cmd_addr_q.push_back(pixel_pair_addr(row, ch_pos));
        cmd_len_q.push_back(burst_len_t'(len));
        ch_pos += 2 * len;
      end
    end
    step  = (t_mode == mode_full_word) ? 2 : 1;
    gsize = rows_per_sa * step;
    for (row = 1; row <= int'(t_poy); row++) begin
      for (grp = 1; grp <= int'(t_pof); grp += gsize) begin
        for (c = 1; c <= gsize && grp - 1 + c <= int'(t_pof); c += step) begin
          ch   = grp - 1 + c;
          idx  = (row - 1) * sa_rows + (grp - 1) / gsize;
          data = fifo_word(idx, cnt[idx]);
          cnt[idx]++;
          read_idx_q.push_back(idx);
          if (t_mode == mode_full_word) begin
            word_addr_q.push_back(pixel_pair_addr(row, ch));
            word_data_q.push_back(data);
          end else if (ch % 2 == 0) begin
            word_addr_q.push_back(pixel_pair_addr(row, ch));
            word_data_q.push_back({data[conv_word_bits-1:0], low_prev});
          end else begin
            low_prev = data[conv_word_bits-1:0];
          end
        end
      end
    end
  endtask

  task automatic run_tile();
    int cyc;
    draw_tile();
    build_model();
    fin_seen    = 0;
    burst_words = 0;
    load_cfg    = 1'b1;
    start_req   = 1'b1;
    step_cycle();
    step_cycle();
    scramble_req = 1'b1;
    cyc = 0;
    while (fin_seen == 0 && cyc < tile_timeout) begin
      step_cycle();
      cyc++;
    end
    if (fin_seen == 0) begin
      stop_run($sformatf("tile %0d did not finish within %0d cycles", tile_no, tile_timeout));
    end
    // quiet until the next start
    for (cyc = 0; cyc < idle_cycles; cyc++) begin
      step_cycle();
    end
    if (burst_words != int'(t_poy) * int'(t_pof) / 2) begin
      report_mismatch($sformatf("tile %0d burst lengths sum to %0d", tile_no, burst_words));
    end
    if (cmd_addr_q.size() != 0 || read_idx_q.size() != 0) begin
      report_mismatch($sformatf("tile %0d left %0d commands and %0d reads undone",
                                tile_no, cmd_addr_q.size(), read_idx_q.size()));
    end
  endtask

  initial begin
    int wait_cnt;
    int t;
    lfsr_state                     = 32'hbec7;
    conv_store_start_sig           = 1'b0;
    ddr_cmd_ready                  = 1'b0;
    ddr_wt_data_ready              = 1'b0;
    output_ddr_layer_base_adr_init = '0;
    mode_init                      = mode_pack_halves;
    of_in_2pow                     = '0;
    ox_in_2pow                     = '0;
    cur_ox_start                   = '0;
    cur_oy_start                   = '0;
    cur_of_start                   = '0;
    cur_pox                        = '0;
    cur_poy                        = '0;
    cur_pof                        = '0;
    fifo_data                      = '0;
    load_cfg                       = 1'b0;
    start_req                      = 1'b0;
    scramble_req                   = 1'b0;
    rd_pend                        = 1'b0;
    rd_pend_idx                    = 0;
    cmd_span                       = 0;
    wt_span                        = 0;
    fin_next                       = 1'b0;
    fin_seen                       = 0;
    burst_words                    = 0;
    tile_no                        = 0;
    errors                         = 0;
    wait_cnt = 0;
    while (reset !== 1'b0 && wait_cnt < reset_timeout) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (reset !== 1'b0) begin
      stop_run("reset was never released by the clock generator");
    end
    // outputs stay idle after reset
    for (t = 0; t < 4; t++) begin
      step_cycle();
    end
    for (t = 0; t < tile_count; t++) begin
      run_tile();
    end
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
src/store_geom_pkg.sv
src/store_types_pkg.sv
src/store_cmd_if.sv
src/store_word_if.sv
src/store_cmd_gen.sv
src/tile_read_walker.sv
src/ddr_word_packer.sv
src/conv_store_top.sv
tb/tb_clock_gen.sv
tb/conv_store_tb.sv

//--- run_sim.sh
#!/bin/sh
# verilator build of the conv_store testbench, then one run scanned for the result
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module conv_store_tb \
  -f compile.f -o conv_store_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/conv_store_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
